// ==== verilog/board_pkg.sv ====
package board_pkg;

    localparam clk_mhz        = 10;
    localparam w_led          = 16;
    localparam w_digit        = 4;
    localparam w_mic          = 24;

    localparam sck_div        = 4;    // clk cycles per sck period.
    localparam bits_per_half  = 32;   // sck periods per ws half.

    // 200 us between display ticks, kept short for simulation.
    localparam tick_cycles    = clk_mhz * 200;
    localparam refresh_cycles = 16;
    localparam led_base_shift = 7;    // LED 0 lights at magnitude 128.

    typedef struct packed {
        logic                     valid;   // One-cycle strobe.
        logic signed [w_mic-1:0]  value;
    } mic_sample_t;

    typedef struct packed {
        logic [7:0]               abcdefgh; // Active high, h is the dot.
        logic [w_digit-1:0]       digit;    // One-hot, active high.
    } seg_out_t;

    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110; // F.
        endcase
    endfunction

endpackage

// ==== verilog/slow_tick_gen.sv ====
module slow_tick_gen
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(tick_cycles)-1:0] cnt;

    // Free-running divider, tick marks the last count.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else begin
            if (cnt == tick_cycles - 1) begin
                cnt  <= '0;
                tick <= 1'b1;
            end
            else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end
    end

    // The display latch expects isolated pulses.
    tick_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        tick |=> !tick
    );

endmodule

// ==== verilog/mic_i2s_receiver.sv ====
module mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample
);

    logic [$clog2(sck_div)-1:0]           div_cnt;
    logic [$clog2(2 * bits_per_half)-1:0] bit_cnt;  // sck periods within a frame.
    logic                                 sck_rise;
    logic                                 sck_fall;
    logic                                 capture;
    logic [w_mic-1:0]                     shreg;
    logic                                 valid_r;

    // sck goes high halfway through the period and low at its end.
    assign sck_rise = div_cnt == sck_div / 2 - 1;
    assign sck_fall = div_cnt == sck_div - 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else begin
            div_cnt <= sck_fall ? '0 : div_cnt + 1'b1;

            if (sck_rise)
                sck <= 1'b1;
            else if (sck_fall)
                sck <= 1'b0;
        end
    end

    // Frame position advances on each falling edge of sck.
    always_ff @(posedge clk) begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall) begin
            if (bit_cnt == 2 * bits_per_half - 1)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Left half first, so ws is low for the first 32 periods.
    assign ws = bit_cnt >= bits_per_half;

    // Bit 0 of the half is the idle slot, the MSB arrives in slot 1.
    assign capture = sck_rise && !ws && bit_cnt >= 1 && bit_cnt <= w_mic;

    always_ff @(posedge clk) begin
        if (capture)
            shreg <= {shreg[w_mic-2:0], sd};
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_r <= 1'b0;
        else
            valid_r <= capture && bit_cnt == w_mic; // LSB just shifted in.
    end

    assign sample = '{valid: valid_r, value: shreg};

    // The microphone changes sd on falling sck, and ws must follow the same edge.
    ws_on_sck_fall: assert property (
        @(posedge clk) disable iff (rst)
        $changed(ws) |-> $fell(sck)
    );

    valid_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        sample.valid |=> !sample.valid
    );

endmodule

// ==== verilog/level_display.sv ====
module level_display
    import board_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mic_sample_t       sample,
    input  logic              tick,
    output logic [w_led-1:0]  led,
    output seg_out_t          seg
);

    logic [w_mic-2:0]                  mag;
    logic [4*w_digit-1:0]              latest;  // Upper bits of the newest sample.
    logic [4*w_digit-1:0]              shown;
    logic [$clog2(refresh_cycles)-1:0] refresh_cnt;
    logic                              refresh_slot;
    logic [$clog2(w_digit)-1:0]        digit_idx;
    logic [$clog2(w_digit)-1:0]        next_idx;

    // Absolute value, the most negative code saturates to full scale.
    always_comb begin
        if (!sample.value[w_mic-1])
            mag = sample.value[w_mic-2:0];
        else if (sample.value[w_mic-2:0] == '0)
            mag = '1;
        else
            mag = (w_mic - 1)'(-sample.value);
    end

    // Bar graph, LED i needs magnitude of at least 2**(i + led_base_shift).
    always_ff @(posedge clk) begin
        if (rst)
            led <= '0;
        else if (sample.valid) begin
            for (int i = 0; i < w_led; i++)
                led[i] <= (mag >> (i + led_base_shift)) != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            latest <= '0;
            shown  <= '0;
        end
        else begin
            if (sample.valid)
                latest <= sample.value[w_mic-1 -: 4*w_digit];

            // A sample that lands together with the tick is shown at once.
            if (tick)
                shown <= sample.valid ? sample.value[w_mic-1 -: 4*w_digit] : latest;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            refresh_cnt <= '0;
        else if (refresh_slot)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign refresh_slot = refresh_cnt == refresh_cycles - 1;

    // First slot after reset starts at digit 0, the low nibble.
    assign next_idx = (seg.digit == '0) ? '0 : digit_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            digit_idx    <= '0;
            seg.digit    <= '0;           // All digits dark until the first slot.
            seg.abcdefgh <= '0;
        end
        else if (refresh_slot) begin
            digit_idx    <= next_idx;
            seg.digit    <= w_digit'(1) << next_idx;
            seg.abcdefgh <= hex_to_seg(shown[4*next_idx +: 4]);
        end
    end

    // Once scanning has begun exactly one digit stays selected.
    digit_one_hot: assert property (
        @(posedge clk) disable iff (rst)
        (seg.digit != '0) |=> $onehot(seg.digit)
    );

endmodule

// ==== verilog/board_specific_top.sv ====
module board_specific_top
    import board_pkg::*;
(
    input  logic               CLK,
    input  logic               rst,

    input  logic               MIC_SD,
    output logic               MIC_SCK,
    output logic               MIC_WS,
    output logic               MIC_LR,

    output logic [w_led-1:0]   LED,

    output logic [7:0]         HGFEDCBA,
    output logic [w_digit-1:0] DIGIT
);

    wire clk = CLK;

    mic_sample_t mic_sample;
    logic        tick;
    seg_out_t    seg;
    logic [7:0]  hgfedcba;

    assign MIC_LR = 1'b0;              // Microphone answers in the left slot.

    mic_i2s_receiver i_mic_i2s_receiver (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .sd     ( MIC_SD     ),
        .sck    ( MIC_SCK    ),
        .ws     ( MIC_WS     ),
        .sample ( mic_sample )
    );

    slow_tick_gen i_slow_tick_gen (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .tick ( tick )
    );

    level_display i_level_display (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .sample ( mic_sample ),
        .tick   ( tick       ),
        .led    ( LED        ),
        .seg    ( seg        )
    );

    // Board wiring runs h down to a, and both segments and digits are active low.
    assign hgfedcba = {<<{seg.abcdefgh}};
    assign HGFEDCBA = ~hgfedcba;
    assign DIGIT    = ~seg.digit;

endmodule

// ==== tb/tb_mic_model.sv ====
module tb_mic_model
    import board_pkg::*;
(
    input  logic             rst,
    input  logic             sck,
    input  logic             ws,
    input  logic [w_mic-1:0] word,
    output logic             sd
);

    timeunit 1ns;
    timeprecision 100ps;

    integer           seed = 32'hc25b0ab7;
    int               slot;          // sck period within the current ws half.
    logic             prev_ws;
    logic [w_mic-1:0] frame_word;    // Sample held for the whole left half.

    // Data changes just after each falling sck, as a real microphone does.
    initial begin
        sd         = 1'b0;
        slot       = 0;
        prev_ws    = 1'b0;
        frame_word = '0;
        forever begin
            @(negedge sck);
            #1;
            if (rst || ws != prev_ws) begin
                slot    = 0;
                prev_ws = ws;
            end
            else
                slot++;

            if (ws)
                sd = 1'($random(seed));  // Right channel carries noise.
            else begin
                if (slot == 0)
                    frame_word = word;
                // MSB in slot 1, trailing slots idle low.
                sd = (slot >= 1 && slot <= w_mic) ? frame_word[w_mic - slot] : 1'b0;
            end
        end
    end

endmodule

// ==== tb/tb_board_specific_top.sv ====
module tb_board_specific_top
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rst;
    logic               mic_sd;
    logic               mic_sck;
    logic               mic_ws;
    logic               mic_lr;
    logic [w_led-1:0]   led;
    logic [7:0]         hgfedcba;
    logic [w_digit-1:0] digit;
    logic [w_mic-1:0]   mic_word;   // Sample the microphone model sends.

    board_specific_top i_board_specific_top (
        .CLK      ( clk      ),
        .rst      ( rst      ),
        .MIC_SD   ( mic_sd   ),
        .MIC_SCK  ( mic_sck  ),
        .MIC_WS   ( mic_ws   ),
        .MIC_LR   ( mic_lr   ),
        .LED      ( led      ),
        .HGFEDCBA ( hgfedcba ),
        .DIGIT    ( digit    )
    );

    tb_mic_model i_mic_model (
        .rst  ( rst      ),
        .sck  ( mic_sck  ),
        .ws   ( mic_ws   ),
        .word ( mic_word ),
        .sd   ( mic_sd   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Drive and sample point, 5 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                name, expected, actual));
    endtask

    task automatic wait_ws(input logic level);
        int n;
        n = 0;
        while (mic_ws !== level) begin
            step();
            n++;
            if (n > 4 * sck_div * bits_per_half)
                abort_run($sformatf("Timeout: MIC_WS never went to %0b.", level));
        end
    endtask

    task automatic wait_tick();
        int n;
        n = 0;
        while (i_board_specific_top.tick !== 1'b1) begin
            step();
            n++;
            if (n > tick_cycles + 8)
                abort_run("Timeout: no display tick arrived.");
        end
    endtask

    task automatic wait_digit(input int idx, input logic level);
        int n;
        n = 0;
        while (digit[idx] !== level) begin
            step();
            n++;
            if (n > 2 * w_digit * refresh_cycles)
                abort_run($sformatf("Timeout: DIGIT[%0d] never went to %0b.", idx, level));
        end
    endtask

    // Called right after ws reaches level, runs until ws leaves it.
    task automatic measure_half(input logic level);
        int   cycles;
        int   rises;
        int   last;
        logic prev;
        cycles = 0;
        rises  = 0;
        last   = -1;
        prev   = mic_sck;
        while (mic_ws === level) begin
            step();
            cycles++;
            if (mic_sck && !prev) begin
                if (last >= 0)
                    check_value("MIC_SCK period", sck_div, cycles - last);
                last = cycles;
                rises++;
            end
            prev = mic_sck;
            if (cycles > 2 * sck_div * bits_per_half)
                abort_run("Timeout: MIC_WS half never ended.");
        end
        check_value($sformatf("ws=%0b half length", level), sck_div * bits_per_half, cycles);
        check_value($sformatf("ws=%0b sck periods", level), bits_per_half, rises);
    endtask

    task automatic check_idle(input string name);
        check_value({name, " LED"}, 0, led);
        check_value({name, " HGFEDCBA"}, 8'hff, hgfedcba);
        check_value({name, " DIGIT"}, {w_digit{1'b1}}, digit);
        check_value({name, " MIC_SCK"}, 0, mic_sck);
        check_value({name, " MIC_WS"}, 0, mic_ws);
        check_value({name, " MIC_LR"}, 0, mic_lr);
    endtask

    task automatic run_case(input int num, input logic [w_mic-1:0] smp,
                            input logic [w_led-1:0] led_exp, input logic [31:0] seg_exp);
        string name;
        name     = $sformatf("case %0d (%h)", num, smp);
        mic_word = smp;
        wait_ws(1'b1);
        wait_ws(1'b0);              // Model picks up the new sample here.
        wait_ws(1'b1);
        wait_ws(1'b0);              // Second frame with the same sample.
        wait_ws(1'b1);
        check_value({name, " LED"}, led_exp, led);

        wait_tick();
        step();                     // Displayed value latches on this edge.
        for (int d = 0; d < w_digit; d++) begin
            wait_digit(d, 1'b1);
            wait_digit(d, 1'b0);
            check_value({name, " active digits"}, 1, $countones(~digit));
            check_value($sformatf("%s digit %0d", name, d), seg_exp[8*d +: 8], hgfedcba);
        end
        // Several noisy right halves have passed by now.
        check_value({name, " LED after scan"}, led_exp, led);
    endtask

    initial begin
        int               fd;
        int               n;
        int               num;
        string            line;
        logic [w_mic-1:0] smp;
        logic [w_led-1:0] led_exp;
        logic [7:0]       seg_exp [w_digit];

        rst      = 1'b1;
        mic_word = '0;
        num      = 0;
        repeat (2) begin
            step();
            check_idle("reset");
        end
        rst = 1'b0;
        step();
        check_idle("after reset");

        wait_ws(1'b1);
        wait_ws(1'b0);
        measure_half(1'b0);
        measure_half(1'b1);

        fd = $fopen("tb/mic_cases.txt", "r");
        if (fd == 0)
            abort_run("Cannot open tb/mic_cases.txt.");
        while ($fgets(line, fd) > 0) begin
            if (line.len() == 0 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h", smp, led_exp,
                        seg_exp[0], seg_exp[1], seg_exp[2], seg_exp[3]);
            if (n != 6)
                continue;
            num++;
            run_case(num, smp, led_exp, {seg_exp[3], seg_exp[2], seg_exp[1], seg_exp[0]});
        end
        $fclose(fd);

        if (num == 0)
            abort_run("No cases found in tb/mic_cases.txt.");
        else begin
            $display("Checked %0d cases.", num);
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== tb/mic_cases.txt ====
# sample(24-bit signed) led(16-bit bar) d0 d1 d2 d3
# d0..d3 are HGFEDCBA (active low) for digits 0..3, digit 0 shows sample bits 11:8
000000 0000 c0 c0 c0 c0
00007f 0000 c0 c0 c0 c0
000080 0001 c0 c0 c0 c0
0001ff 0003 f9 c0 c0 c0
123456 3fff 99 b0 a4 f9
7fffff ffff 8e 8e 8e f8
800000 ffff c0 c0 c0 80
ffffff 0000 8e 8e 8e 8e
ffff00 0003 8e 8e 8e 8e
ffff80 0001 8e 8e 8e 8e
abcdef ffff a1 c6 83 88
09a5c3 1fff 92 88 90 c0
f00000 3fff c0 c0 c0 8e
006e00 00ff 86 82 c0 c0
c3b2d1 7fff a4 83 b0 c6

// ==== board_specific_top.f ====
verilog/board_pkg.sv
verilog/slow_tick_gen.sv
verilog/mic_i2s_receiver.sv
verilog/level_display.sv
verilog/board_specific_top.sv
tb/tb_mic_model.sv
tb/tb_board_specific_top.sv
